//--- logic/rs_dispatch.sv
`timescale 1ns/1ps

module rs_dispatch
    import rs_pkg::*;
(
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                flush,
    input  logic                dispatch_valid,
    input  logic [DEC_OP_W-1:0] dispatch_op,
    input  logic [REG_W-1:0]    dispatch_rd,
    input  logic [REG_W-1:0]    dispatch_rs1,
    input  logic [REG_W-1:0]    dispatch_rs2,
    input  logic [XLEN-1:0]     dispatch_rs1_value,
    input  logic [XLEN-1:0]     dispatch_rs2_value,
    input  logic [XLEN-1:0]     dispatch_imm,
    input  logic [TAG_W-1:0]    dispatch_tag,
    input  logic                bcast_valid,
    input  logic [TAG_W-1:0]    bcast_tag,
    input  logic [XLEN-1:0]     bcast_data,
    rs_dispatch_if.producer     dp
);
    // rename table, one busy bit and newest writer tag per register
    logic [NUM_REGS-1:0] ren_busy;
    logic [TAG_W-1:0]    ren_tag [NUM_REGS];

    logic [ALU_OP_W-1:0] alu_op;
    logic                is_imm;
    logic                accept;
    logic                rs1_hit;
    logic                rs2_hit;

    always_comb begin
        alu_op = ALU_ADD;
        case (dispatch_op)
            DEC_ADD,  DEC_ADDI:  alu_op = ALU_ADD;
            DEC_SUB,  DEC_SUBI:  alu_op = ALU_SUB;
            DEC_AND,  DEC_ANDI:  alu_op = ALU_AND;
            DEC_OR,   DEC_ORI:   alu_op = ALU_OR;
            DEC_XOR,  DEC_XORI:  alu_op = ALU_XOR;
            DEC_SLL,  DEC_SLLI:  alu_op = ALU_SLL;
            DEC_SRL,  DEC_SRLI:  alu_op = ALU_SRL;
            DEC_SRA,  DEC_SRAI:  alu_op = ALU_SRA;
            DEC_SLT,  DEC_SLTI:  alu_op = ALU_SLT;
            DEC_SLTU, DEC_SLTIU: alu_op = ALU_SLTU;
            default:             alu_op = ALU_ADD;
        endcase
    end

    assign is_imm = (dispatch_op >= DEC_ADDI) && (dispatch_op <= DEC_SLTIU);
    assign accept = dispatch_valid && dp.ready;

    // a broadcast of the pending tag in this very cycle is forwarded directly
    assign rs1_hit = bcast_valid && (bcast_tag == ren_tag[dispatch_rs1]);
    assign rs2_hit = bcast_valid && (bcast_tag == ren_tag[dispatch_rs2]);

    assign dp.valid    = accept;
    assign dp.alu_op   = alu_op;
    assign dp.rd       = dispatch_rd;
    assign dp.tag      = dispatch_tag;
    assign dp.vj       = ren_busy[dispatch_rs1] ? bcast_data : dispatch_rs1_value;
    assign dp.vj_ready = !ren_busy[dispatch_rs1] || rs1_hit;
    assign dp.qj       = ren_tag[dispatch_rs1];
    assign dp.vk       = is_imm ? dispatch_imm :
                         ren_busy[dispatch_rs2] ? bcast_data : dispatch_rs2_value;
    assign dp.vk_ready = is_imm || !ren_busy[dispatch_rs2] || rs2_hit;
    assign dp.qk       = ren_tag[dispatch_rs2];

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            ren_busy <= '0;
        end else if (flush) begin
            ren_busy <= '0;
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (bcast_valid && (ren_tag[r] == bcast_tag)) begin
                    ren_busy[r] <= 1'b0;
                end
            end
            // the new mapping wins over a same-cycle clear of the same register
            if (accept) begin
                ren_busy[dispatch_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            ren_tag[dispatch_rd] <= dispatch_tag;
        end
    end
endmodule

//--- logic/rs_dispatch_if.sv
`timescale 1ns/1ps

interface rs_dispatch_if
    import rs_pkg::*;
();
    logic                valid;
    logic [ALU_OP_W-1:0] alu_op;
    logic [REG_W-1:0]    rd;
    logic [TAG_W-1:0]    tag;

    // an operand either carries its value or the tag it waits on
    logic [XLEN-1:0]     vj;
    logic                vj_ready;
    logic [TAG_W-1:0]    qj;
    logic [XLEN-1:0]     vk;
    logic                vk_ready;
    logic [TAG_W-1:0]    qk;

    // high while the station has at least one free entry
    logic                ready;

    modport producer (
        output valid, alu_op, rd, tag, vj, vj_ready, qj, vk, vk_ready, qk,
        input  ready
    );

    modport station (
        input  valid, alu_op, rd, tag, vj, vj_ready, qj, vk, vk_ready, qk,
        output ready
    );
endinterface

//--- logic/rs_execute.sv
`timescale 1ns/1ps

module rs_execute
    import rs_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             flush,
    rs_issue_if.execute      iss,
    output logic             complete_valid,
    output logic [TAG_W-1:0] complete_tag,
    output logic [REG_W-1:0] complete_rd,
    output logic [XLEN-1:0]  complete_result
);
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    result;

    assign shamt = iss.b[SHAMT_W-1:0];

    always_comb begin
        case (iss.alu_op)
            ALU_ADD:  result = iss.a + iss.b;
            ALU_SUB:  result = iss.a - iss.b;
            ALU_AND:  result = iss.a & iss.b;
            ALU_OR:   result = iss.a | iss.b;
            ALU_XOR:  result = iss.a ^ iss.b;
            ALU_SLL:  result = iss.a << shamt;
            ALU_SRL:  result = iss.a >> shamt;
            ALU_SRA:  result = $unsigned($signed(iss.a) >>> shamt);
            // comparisons give a single set bit or zero
            ALU_SLT:  result = {{(XLEN - 1){1'b0}}, $signed(iss.a) < $signed(iss.b)};
            ALU_SLTU: result = {{(XLEN - 1){1'b0}}, iss.a < iss.b};
            default:  result = '0;
        endcase
    end

    // completion is a single-cycle pulse toward the reorder buffer
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            complete_valid <= 1'b0;
        end else if (flush) begin
            complete_valid <= 1'b0;
        end else begin
            complete_valid <= iss.valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (iss.valid) begin
            complete_tag    <= iss.tag;
            complete_rd     <= iss.rd;
            complete_result <= result;
        end
    end
endmodule

//--- logic/rs_issue_if.sv
`timescale 1ns/1ps

interface rs_issue_if
    import rs_pkg::*;
();
    logic                valid;
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     a;
    logic [XLEN-1:0]     b;
    logic [TAG_W-1:0]    tag;
    logic [REG_W-1:0]    rd;

    // the execute side always takes what is issued
    modport station (
        output valid, alu_op, a, b, tag, rd
    );

    modport execute (
        input  valid, alu_op, a, b, tag, rd
    );
endinterface

//--- logic/rs_pkg.sv
package rs_pkg;

    // datapath, register index and reorder tag widths
    localparam int XLEN     = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int TAG_W    = 4;

    // station depth and the width needed to index it
    localparam int RS_SIZE  = 4;
    localparam int RS_IDX_W = 2;

    // shifts only look at the low bits of the b operand
    localparam int SHAMT_W  = 5;

    localparam int DEC_OP_W = 6;

    // register forms first, then the immediate forms in the same operation order
    localparam logic [DEC_OP_W-1:0] DEC_ADD   = 6'd0;
    localparam logic [DEC_OP_W-1:0] DEC_SUB   = 6'd1;
    localparam logic [DEC_OP_W-1:0] DEC_AND   = 6'd2;
    localparam logic [DEC_OP_W-1:0] DEC_OR    = 6'd3;
    localparam logic [DEC_OP_W-1:0] DEC_XOR   = 6'd4;
    localparam logic [DEC_OP_W-1:0] DEC_SLL   = 6'd5;
    localparam logic [DEC_OP_W-1:0] DEC_SRL   = 6'd6;
    localparam logic [DEC_OP_W-1:0] DEC_SRA   = 6'd7;
    localparam logic [DEC_OP_W-1:0] DEC_SLT   = 6'd8;
    localparam logic [DEC_OP_W-1:0] DEC_SLTU  = 6'd9;
    localparam logic [DEC_OP_W-1:0] DEC_ADDI  = 6'd10;
    localparam logic [DEC_OP_W-1:0] DEC_SUBI  = 6'd11;
    localparam logic [DEC_OP_W-1:0] DEC_ANDI  = 6'd12;
    localparam logic [DEC_OP_W-1:0] DEC_ORI   = 6'd13;
    localparam logic [DEC_OP_W-1:0] DEC_XORI  = 6'd14;
    localparam logic [DEC_OP_W-1:0] DEC_SLLI  = 6'd15;
    localparam logic [DEC_OP_W-1:0] DEC_SRLI  = 6'd16;
    localparam logic [DEC_OP_W-1:0] DEC_SRAI  = 6'd17;
    localparam logic [DEC_OP_W-1:0] DEC_SLTI  = 6'd18;
    localparam logic [DEC_OP_W-1:0] DEC_SLTIU = 6'd19;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;

endpackage

//--- logic/rs_station.sv
`timescale 1ns/1ps

module rs_station
    import rs_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             flush,
    input  logic             bcast_valid,
    input  logic [TAG_W-1:0] bcast_tag,
    input  logic [XLEN-1:0]  bcast_data,
    rs_dispatch_if.station   dp,
    rs_issue_if.station      iss,
    output logic             dispatch_ready
);
    logic [RS_SIZE-1:0]  busy;
    logic [RS_SIZE-1:0]  vj_ready;
    logic [RS_SIZE-1:0]  vk_ready;
    logic [ALU_OP_W-1:0] alu_op [RS_SIZE];
    logic [REG_W-1:0]    rd     [RS_SIZE];
    logic [TAG_W-1:0]    tag    [RS_SIZE];
    logic [XLEN-1:0]     vj     [RS_SIZE];
    logic [TAG_W-1:0]    qj     [RS_SIZE];
    logic [XLEN-1:0]     vk     [RS_SIZE];
    logic [TAG_W-1:0]    qk     [RS_SIZE];

    logic [RS_SIZE-1:0]  wake_j;
    logic [RS_SIZE-1:0]  wake_k;
    logic [RS_IDX_W-1:0] free_idx;
    logic [RS_IDX_W-1:0] issue_idx;
    logic                issue_found;

    assign dispatch_ready = ~&busy;
    assign dp.ready       = dispatch_ready;

    // scanning downwards leaves the lowest matching index in place
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_found = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = RS_IDX_W'(i);
            end
            if (busy[i] && vj_ready[i] && vk_ready[i]) begin
                issue_found = 1'b1;
                issue_idx   = RS_IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            wake_j[i] = bcast_valid && busy[i] && !vj_ready[i] && (qj[i] == bcast_tag);
            wake_k[i] = bcast_valid && busy[i] && !vk_ready[i] && (qk[i] == bcast_tag);
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            busy      <= '0;
            vj_ready  <= '0;
            vk_ready  <= '0;
            iss.valid <= 1'b0;
        end else if (flush) begin
            busy      <= '0;
            vj_ready  <= '0;
            vk_ready  <= '0;
            iss.valid <= 1'b0;
        end else begin
            vj_ready <= vj_ready | wake_j;
            vk_ready <= vk_ready | wake_k;
            // the free slot is never the issuing one, so both updates can land together
            if (dp.valid) begin
                busy[free_idx]     <= 1'b1;
                vj_ready[free_idx] <= dp.vj_ready;
                vk_ready[free_idx] <= dp.vk_ready;
            end
            if (issue_found) begin
                busy[issue_idx] <= 1'b0;
            end
            iss.valid <= issue_found;
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (wake_j[i]) begin
                vj[i] <= bcast_data;
            end
            if (wake_k[i]) begin
                vk[i] <= bcast_data;
            end
        end
        if (dp.valid) begin
            alu_op[free_idx] <= dp.alu_op;
            rd[free_idx]     <= dp.rd;
            tag[free_idx]    <= dp.tag;
            vj[free_idx]     <= dp.vj;
            qj[free_idx]     <= dp.qj;
            vk[free_idx]     <= dp.vk;
            qk[free_idx]     <= dp.qk;
        end
        if (issue_found) begin
            iss.alu_op <= alu_op[issue_idx];
            iss.a      <= vj[issue_idx];
            iss.b      <= vk[issue_idx];
            iss.tag    <= tag[issue_idx];
            iss.rd     <= rd[issue_idx];
        end
    end
endmodule

//--- logic/rs_top.sv
`timescale 1ns/1ps

module rs_top
    import rs_pkg::*;
(
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                dispatch_valid,
    input  logic [DEC_OP_W-1:0] dispatch_op,
    input  logic [REG_W-1:0]    dispatch_rd,
    input  logic [REG_W-1:0]    dispatch_rs1,
    input  logic [REG_W-1:0]    dispatch_rs2,
    input  logic [XLEN-1:0]     dispatch_rs1_value,
    input  logic [XLEN-1:0]     dispatch_rs2_value,
    input  logic [XLEN-1:0]     dispatch_imm,
    input  logic [TAG_W-1:0]    dispatch_tag,
    input  logic                bcast_valid,
    input  logic [TAG_W-1:0]    bcast_tag,
    input  logic [XLEN-1:0]     bcast_data,
    input  logic                flush,
    output logic                dispatch_ready,
    output logic                complete_valid,
    output logic [TAG_W-1:0]    complete_tag,
    output logic [REG_W-1:0]    complete_rd,
    output logic [XLEN-1:0]     complete_result
);
    rs_dispatch_if dp_if ();
    rs_issue_if    iss_if ();

    // renamed entries flow dispatch -> station -> execute
    rs_dispatch dispatch0 (
        .clk_in             (clk_in),
        .rst_in             (rst_in),
        .flush              (flush),
        .dispatch_valid     (dispatch_valid),
        .dispatch_op        (dispatch_op),
        .dispatch_rd        (dispatch_rd),
        .dispatch_rs1       (dispatch_rs1),
        .dispatch_rs2       (dispatch_rs2),
        .dispatch_rs1_value (dispatch_rs1_value),
        .dispatch_rs2_value (dispatch_rs2_value),
        .dispatch_imm       (dispatch_imm),
        .dispatch_tag       (dispatch_tag),
        .bcast_valid        (bcast_valid),
        .bcast_tag          (bcast_tag),
        .bcast_data         (bcast_data),
        .dp                 (dp_if.producer)
    );

    rs_station station0 (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .flush          (flush),
        .bcast_valid    (bcast_valid),
        .bcast_tag      (bcast_tag),
        .bcast_data     (bcast_data),
        .dp             (dp_if.station),
        .iss            (iss_if.station),
        .dispatch_ready (dispatch_ready)
    );

    rs_execute execute0 (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .flush           (flush),
        .iss             (iss_if.execute),
        .complete_valid  (complete_valid),
        .complete_tag    (complete_tag),
        .complete_rd     (complete_rd),
        .complete_result (complete_result)
    );
endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rs_tb -f sources.f -o rs_sim

out=$(./obj_dir/rs_sim)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

//--- sources.f
logic/rs_pkg.sv
logic/rs_dispatch_if.sv
logic/rs_issue_if.sv
logic/rs_dispatch.sv
logic/rs_station.sv
logic/rs_execute.sv
logic/rs_top.sv
verification/rs_sva.sv
verification/rs_tb.sv

//--- verification/rs_sva.sv
`timescale 1ns/1ps

module rs_sva
    import rs_pkg::*;
(
    input logic                clk_in,
    input logic                rst_in,
    input logic                flush,
    input logic                issue_valid,
    input logic                write_valid,
    input logic [RS_SIZE-1:0]  slot_busy,
    input logic [RS_IDX_W-1:0] write_slot,
    input logic                dispatch_ready,
    input logic                complete_valid
);
    // an issued operation completes on the next edge unless it is flushed
    assert property (@(posedge clk_in) disable iff (rst_in)
        (issue_valid && !flush) |=> complete_valid)
        else $error("issue was not followed by a completion");

    assert property (@(posedge clk_in) disable iff (rst_in)
        !issue_valid |=> !complete_valid)
        else $error("completion without a preceding issue");

    // a write must land in a free slot, which also rules out a write into a full station
    assert property (@(posedge clk_in) disable iff (rst_in)
        write_valid |-> !slot_busy[write_slot])
        else $error("entry written into an occupied slot");

    assert property (@(posedge clk_in) rst_in |-> dispatch_ready)
        else $error("dispatch_ready low during reset");
endmodule

bind rs_top rs_sva sva0 (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .flush          (flush),
    .issue_valid    (iss_if.valid),
    .write_valid    (dp_if.valid),
    .slot_busy      (station0.busy),
    .write_slot     (station0.free_idx),
    .dispatch_ready (dispatch_ready),
    .complete_valid (complete_valid)
);

//--- verification/rs_tb.sv
`timescale 1ns/1ps

module rs_tb
    import rs_pkg::*;
();
    localparam int TEST_CYCLES = 16 + 40 + 40 + 60 + 60 + 80 + 60;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * 100;

    logic clk_in;
    logic rst_in;
    logic dispatch_valid;
    logic [DEC_OP_W-1:0] dispatch_op;
    logic [REG_W-1:0] dispatch_rd;
    logic [REG_W-1:0] dispatch_rs1;
    logic [REG_W-1:0] dispatch_rs2;
    logic [XLEN-1:0] dispatch_rs1_value;
    logic [XLEN-1:0] dispatch_rs2_value;
    logic [XLEN-1:0] dispatch_imm;
    logic [TAG_W-1:0] dispatch_tag;
    logic bcast_valid;
    logic [TAG_W-1:0] bcast_tag;
    logic [XLEN-1:0] bcast_data;
    logic flush;
    logic dispatch_ready;
    logic complete_valid;
    logic [TAG_W-1:0] complete_tag;
    logic [REG_W-1:0] complete_rd;
    logic [XLEN-1:0] complete_result;

    // scoreboard indexed by tag
    logic exp_pending [16];
    logic [REG_W-1:0] exp_rd [16];
    logic [XLEN-1:0] exp_result [16];
    int exp_cycle [16];
    logic [TAG_W-1:0] done_q [$];
    logic [31:0] lcg_state = 32'ha214cac5;
    int cyc = 0;
    int errors = 0;
    int tests = 0;

    rs_top dut0 (.*);

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected ALU result from the operation rules, register and immediate forms alike
    function automatic logic [XLEN-1:0] alu_model(input logic [DEC_OP_W-1:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        int sel;
        sel = int'(op) % 10;
        case (sel)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return a << b[4:0];
            6: return a >> b[4:0];
            7: return $unsigned($signed(a) >>> b[4:0]);
            8: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic check_result(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(input logic [REG_W-1:0] got, input logic [REG_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got x%0d expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // completions are matched against the scoreboard on the falling edge
    always @(negedge clk_in) begin
        cyc <= cyc + 1;
        if (!rst_in && complete_valid) begin
            if (!exp_pending[complete_tag]) begin
                errors++;
                $display("unexpected completion for tag %0d at %0t", complete_tag, $time);
            end else begin
                check_rd(complete_rd, exp_rd[complete_tag], "completion rd");
                check_result(complete_result, exp_result[complete_tag], "completion result");
                if (exp_cycle[complete_tag] != cyc) begin
                    errors++;
                    $display("Fail %0t: tag %0d completed in cycle %0d, expected %0d",
                             $time, complete_tag, cyc, exp_cycle[complete_tag]);
                end
                exp_pending[complete_tag] = 1'b0;
                done_q.push_back(complete_tag);
            end
        end
    end

    task automatic drive_cycle(input logic dv, input logic [DEC_OP_W-1:0] op,
                               input logic [REG_W-1:0] rd, input logic [REG_W-1:0] rs1,
                               input logic [XLEN-1:0] v1, input logic [XLEN-1:0] v2,
                               input logic [XLEN-1:0] imm, input logic [TAG_W-1:0] tag,
                               input logic bv, input logic [TAG_W-1:0] btag,
                               input logic [XLEN-1:0] bdata);
        @(posedge clk_in);
        dispatch_valid     <= dv;
        dispatch_op        <= op;
        dispatch_rd        <= rd;
        dispatch_rs1       <= rs1;
        dispatch_rs2       <= 5'd21;
        dispatch_rs1_value <= v1;
        dispatch_rs2_value <= v2;
        dispatch_imm       <= imm;
        dispatch_tag       <= tag;
        bcast_valid        <= bv;
        bcast_tag          <= btag;
        bcast_data         <= bdata;
    endtask

    task automatic send_op(input logic [DEC_OP_W-1:0] op, input logic [REG_W-1:0] rd,
                           input logic [REG_W-1:0] rs1, input logic [XLEN-1:0] v1,
                           input logic [XLEN-1:0] v2, input logic [XLEN-1:0] imm,
                           input logic [TAG_W-1:0] tag);
        drive_cycle(1'b1, op, rd, rs1, v1, v2, imm, tag, 1'b0, 4'd0, 32'd0);
    endtask

    task automatic send_bcast(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] data);
        drive_cycle(1'b0, DEC_ADD, 5'd0, 5'd0, 32'd0, 32'd0, 32'd0, 4'd0, 1'b1, tag, data);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, DEC_ADD, 5'd0, 5'd0, 32'd0, 32'd0, 32'd0, 4'd0,
                               1'b0, 4'd0, 32'd0);
    endtask

    // a ready operation driven now completes three cycles later in the monitor's count
    task automatic expect_done(input logic [TAG_W-1:0] tag, input logic [REG_W-1:0] rd,
                               input logic [XLEN-1:0] result);
        exp_pending[tag] = 1'b1;
        exp_rd[tag]      = rd;
        exp_result[tag]  = result;
        exp_cycle[tag]   = cyc + 3;
    endtask

    task automatic wait_all(input int max_cycles);
        int n;
        logic busy;
        n = 0;
        busy = 1'b1;
        while (busy && n < max_cycles) begin
            @(posedge clk_in);
            busy = 1'b0;
            foreach (exp_pending[t]) busy |= exp_pending[t];
            n++;
        end
        if (busy) begin
            errors++;
            $display("timed out waiting for expected completions at %0t", $time);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "errors");
    endtask

    task automatic test_register_ops();
        int e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        e = errors;
        for (int i = 0; i < 10; i++) begin
            a = lcg_next();
            b = lcg_next();
            send_op(DEC_OP_W'(i), REG_W'(i + 1), 5'd20, a, b, 32'd0, TAG_W'(i));
            expect_done(TAG_W'(i), REG_W'(i + 1), alu_model(DEC_OP_W'(i), a, b));
        end
        idle_cycles(1);
        wait_all(20);
        report_test("register operations", e);
    endtask

    task automatic test_immediate_ops();
        int e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] imm;
        e = errors;
        for (int i = 0; i < 10; i++) begin
            a = lcg_next();
            imm = lcg_next();
            send_op(DEC_OP_W'(i + 10), REG_W'(i + 1), 5'd20, a, lcg_next(), imm, TAG_W'(i));
            expect_done(TAG_W'(i), REG_W'(i + 1), alu_model(DEC_OP_W'(i + 10), a, imm));
        end
        idle_cycles(1);
        wait_all(20);
        report_test("immediate operations", e);
    endtask

    task automatic test_rename_wakeup();
        int e;
        logic [XLEN-1:0] d;
        e = errors;
        send_op(DEC_ADD, 5'd5, 5'd20, 32'd1, 32'd2, 32'd0, 4'd3);
        expect_done(4'd3, 5'd5, 32'd3);
        send_op(DEC_ADDI, 5'd6, 5'd5, 32'hdead0000, 32'd0, 32'd16, 4'd4);
        idle_cycles(6);
        d = lcg_next();
        send_bcast(4'd3, d);
        expect_done(4'd4, 5'd6, d + 32'd16);
        idle_cycles(1);
        wait_all(10);
        // broadcast and dispatch in one cycle, the operand comes from the bypass
        send_op(DEC_ADD, 5'd7, 5'd20, 32'd4, 32'd5, 32'd0, 4'd5);
        expect_done(4'd5, 5'd7, 32'd9);
        idle_cycles(1);
        wait_all(10);
        d = lcg_next();
        drive_cycle(1'b1, DEC_XORI, 5'd9, 5'd7, 32'hbad0bad0, 32'd0, 32'h55, 4'd6,
                    1'b1, 4'd5, d);
        expect_done(4'd6, 5'd9, d ^ 32'h55);
        idle_cycles(1);
        wait_all(10);
        report_test("renaming and wakeup", e);
    endtask

    task automatic test_stale_tag();
        int e;
        logic [XLEN-1:0] d;
        e = errors;
        send_op(DEC_ADD, 5'd8, 5'd20, 32'd10, 32'd1, 32'd0, 4'd7);
        expect_done(4'd7, 5'd8, 32'd11);
        send_op(DEC_SUB, 5'd8, 5'd20, 32'd10, 32'd1, 32'd0, 4'd8);
        expect_done(4'd8, 5'd8, 32'd9);
        idle_cycles(1);
        wait_all(10);
        send_bcast(4'd7, 32'h1234);
        send_op(DEC_ADDI, 5'd11, 5'd8, 32'hbad00000, 32'd0, 32'd2, 4'd9);
        idle_cycles(6);
        d = lcg_next();
        send_bcast(4'd8, d);
        expect_done(4'd9, 5'd11, d + 32'd2);
        idle_cycles(1);
        wait_all(10);
        report_test("stale tag", e);
    endtask

    task automatic test_full_station();
        int e;
        int base;
        logic [XLEN-1:0] d;
        e = errors;
        for (int i = 0; i < 4; i++) begin
            send_op(DEC_OR, REG_W'(10 + i), 5'd20, 32'd0, 32'd7, 32'd0, TAG_W'(10 + i));
            expect_done(TAG_W'(10 + i), REG_W'(10 + i), 32'd7);
        end
        idle_cycles(1);
        wait_all(20);
        for (int i = 0; i < 4; i++) begin
            send_op(DEC_ADDI, REG_W'(16 + i), REG_W'(10 + i), 32'd0, 32'd0,
                    XLEN'(i + 1), TAG_W'(i));
        end
        idle_cycles(1);
        @(negedge clk_in);
        check_flag(dispatch_ready, 1'b0, "dispatch_ready with four waiting entries");
        send_op(DEC_ADD, 5'd22, 5'd20, 32'd1, 32'd1, 32'd0, 4'd4);
        idle_cycles(6);
        base = done_q.size();
        for (int i = 0; i < 4; i++) begin
            d = lcg_next();
            send_bcast(TAG_W'(10 + i), d);
            expect_done(TAG_W'(i), REG_W'(16 + i), d + XLEN'(i + 1));
        end
        idle_cycles(1);
        wait_all(20);
        for (int i = 0; i < 4; i++) begin
            if (done_q.size() > base + i) begin
                check_tag(done_q[base + i], TAG_W'(i), "drain order");
            end
        end
        @(negedge clk_in);
        check_flag(dispatch_ready, 1'b1, "dispatch_ready after draining");
        report_test("full station", e);
    endtask

    task automatic test_flush();
        int e;
        e = errors;
        send_op(DEC_ADD, 5'd15, 5'd20, 32'd3, 32'd3, 32'd0, 4'd1);
        expect_done(4'd1, 5'd15, 32'd6);
        idle_cycles(1);
        wait_all(10);
        // four operations wait on x15 and fill the station
        send_op(DEC_ADDI, 5'd23, 5'd15, 32'd0, 32'd0, 32'd1, 4'd2);
        send_op(DEC_XORI, 5'd24, 5'd15, 32'd0, 32'd0, 32'd1, 4'd3);
        send_op(DEC_ORI, 5'd26, 5'd15, 32'd0, 32'd0, 32'd1, 4'd6);
        send_op(DEC_ANDI, 5'd27, 5'd15, 32'd0, 32'd0, 32'd1, 4'd7);
        idle_cycles(1);
        @(negedge clk_in);
        check_flag(dispatch_ready, 1'b0, "dispatch_ready before flush");
        @(posedge clk_in);
        flush <= 1'b1;
        @(posedge clk_in);
        flush <= 1'b0;
        @(negedge clk_in);
        check_flag(dispatch_ready, 1'b1, "dispatch_ready after flush");
        // x15 is no longer renamed, so the supplied value is used
        send_op(DEC_ADDI, 5'd25, 5'd15, 32'd100, 32'd0, 32'd5, 4'd5);
        expect_done(4'd5, 5'd25, 32'd105);
        idle_cycles(1);
        wait_all(10);
        // the squashed entries are gone and cannot wake on their tag
        send_bcast(4'd1, 32'h77);
        idle_cycles(5);
        report_test("flush", e);
    endtask

    initial begin
        foreach (exp_pending[t]) begin
            exp_pending[t] = 1'b0;
            exp_cycle[t]   = 0;
        end
        rst_in             = 1'b1;
        flush              = 1'b0;
        dispatch_valid     = 1'b0;
        dispatch_op        = '0;
        dispatch_rd        = '0;
        dispatch_rs1       = '0;
        dispatch_rs2       = '0;
        dispatch_rs1_value = '0;
        dispatch_rs2_value = '0;
        dispatch_imm       = '0;
        dispatch_tag       = '0;
        bcast_valid        = 1'b0;
        bcast_tag          = '0;
        bcast_data         = '0;
        repeat (16) @(posedge clk_in);
        rst_in <= 1'b0;
        idle_cycles(2);
        test_register_ops();
        test_immediate_ops();
        test_rename_wakeup();
        test_stale_tag();
        test_full_station();
        test_flush();
        idle_cycles(4);
        $display("tests %0d, completions %0d, errors %0d", tests, done_q.size(), errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule
